//--- bench/calc_testdata.txt
# a  op  b  value  overflow  stall   (op 10 add, 11 sub, 12 mul; 16 added keys junk then clear)
# a and b are keyed as decimal digits, value and overflow are what the display must get
12 10 30 42 0 0
65535 10 1 0 1 0
40000 10 30000 4464 1 2
100 11 58 42 0 0
3 11 5 65534 1 1
0 11 0 0 0 0
123 12 45 5535 0 0
300 12 300 24464 1 3
65535 12 65535 1 1 0
256 12 256 0 1 0
7 26 8 15 0 0
1000 27 1 999 0 4
1234567 10 0 54919 0 0
100000 12 1 34464 0 2
9999999 11 1 38526 0 5
65535 12 1 65535 0 0
2 12 3 6 0 6

//--- project.f
rtl/key_pkg.sv
rtl/calc_pkg.sv
rtl/shift_add_multiplier.sv
rtl/key_entry.sv
rtl/calc_control.sv
rtl/result_stage.sv
rtl/calc_top.sv
bench/calc_properties.sv
bench/calc_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
LINTFLAGS = --lint-only --timing
TOP       = calc_tb
FILELIST  = project.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "Simulation passed" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/calc_tb.sv
`timescale 1ns/10ps

module calc_tb;
    import key_pkg::*;
    import calc_pkg::*;

    localparam int WIDTH = DATA_WIDTH;
    localparam int DRIVE = 10;      // ns after the rising edge

    typedef struct packed {
        int a;
        int op;     // Key code, 16 added for junk entry then clear
        int b;
        int value;
        int ovf;
        int stall;  // Cycles result_ready stays low
    } vector_t;

    logic         clk = 1'b0;
    logic         nRST;
    key_event_t   key;
    logic         result_ready;
    calc_result_t result;
    logic         result_valid;
    vector_t      vectors[$];
    vector_t      expect_q[$];      // Keyed, not yet shown
    integer       seed = 18201;
    int           checked = 0;
    longint       limit_ns = 0;

    calc_top #(.WIDTH(WIDTH)) i_dut (.*);

    always #50 clk = ~clk;

    function automatic int count_digits(input int value);
        int n = 1;
        while (value > 9) begin
            value = value / 10;
            n++;
        end
        return n;
    endfunction

    task automatic compare_values(input logic [63:0] actual, input logic [63:0] expected,
                                  input string what);
        if (actual !== expected) begin
            $display("Fail at %0d ns: %s is %0d, expected %0d", $time, what, actual, expected);
            $display("Simulation failed");
            $fatal(1, "Mismatch on %s", what);
        end
    endtask

    task automatic load_vectors();
        int fd;
        int a, op, b, value, ovf, stall;
        logic [8*200-1:0] line;
        fd = $fopen("bench/calc_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open bench/calc_testdata.txt");
            $display("Simulation failed");
            $fatal(1, "No test data");
        end
        while (!$feof(fd)) begin
            line = '0;
            void'($fgets(line, fd));
            if ($sscanf(line, "%d %d %d %d %d %d", a, op, b, value, ovf, stall) == 6) begin
                vectors.push_back('{a, op, b, value, ovf, stall});  // Comment lines skipped
            end
        end
        $fclose(fd);
    endtask

    task automatic drive_key(input bit press, input int code);
        @(posedge clk);
        #DRIVE;
        key.press = press;
        key.code  = key_code_t'(code[3:0]);
    endtask

    task automatic press_key(input int code);
        int gap;
        gap = $unsigned($random(seed)) % 3;     // Idle cycles before the key
        repeat (gap) drive_key(1'b0, 0);
        drive_key(1'b1, code);
    endtask

    task automatic key_number(input int value);
        int digits[$];
        int n;
        n = value;
        if (n == 0) digits.push_back(0);
        while (n > 0) begin
            digits.push_front(n % 10);          // Most significant first
            n = n / 10;
        end
        foreach (digits[i]) press_key(digits[i]);
    endtask

    task automatic key_calculation(input vector_t v);
        int op;
        op = v.op % 16;
        if (v.op >= 16) begin
            key_number($unsigned($random(seed)) % 1000);
            press_key(op);
            key_number($unsigned($random(seed)) % 100);
            press_key(KEY_CLEAR);               // Drop both operands mid entry
        end
        key_number(v.a);
        press_key(op);
        key_number(v.b);
        expect_q.push_back(v);
        press_key(KEY_EQUAL);
        drive_key(1'b0, 0);
        do @(negedge clk); while (!(i_dut.job_valid && i_dut.job_ready));  // Keys lost while pending
    endtask

    initial begin : monitor
        vector_t exp;
        @(negedge nRST);
        forever begin
            while (expect_q.size() == 0) @(negedge clk);
            exp = expect_q.pop_front();
            while (!result_valid) @(negedge clk);
            repeat (exp.stall) @(posedge clk);  // Display busy
            @(posedge clk);
            #DRIVE result_ready = 1'b1;
            @(negedge clk);
            compare_values(result_valid, 1, "result_valid during stall");
            compare_values(result.value, exp.value, "result value");
            compare_values(result.overflow, exp.ovf, "result overflow");
            checked++;
            @(posedge clk);
            #DRIVE result_ready = 1'b0;
        end
    end

    initial begin : watchdog
        wait (limit_ns > 0);
        #(limit_ns);
        $display("Watchdog expired after %0d ns, %0d of %0d results seen",
                 limit_ns, checked, vectors.size());
        $display("Simulation failed");
        $fatal(1, "Timeout");
    end

    initial begin : main
        key          = '0;
        result_ready = 1'b0;
        nRST         = 1'b1;
        load_vectors();
        if (vectors.size() == 0) begin
            $display("The test data file holds no calculation");
            $display("Simulation failed");
            $fatal(1, "Empty test data");
        end
        foreach (vectors[i]) begin
            limit_ns += 100 * (3 * (count_digits(vectors[i].a) + count_digits(vectors[i].b) + 10)
                               + vectors[i].stall + WIDTH + 20);
        end
        repeat (2) @(posedge clk);
        #DRIVE nRST = 1'b0;
        foreach (vectors[i]) key_calculation(vectors[i]);
        while (checked < vectors.size()) @(negedge clk);
        repeat (4) begin
            @(negedge clk);
            compare_values(result_valid, 0, "result_valid after the last result");
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

//--- bench/calc_properties.sv
`timescale 1ns/10ps

module calc_properties (
    input logic                   clk,
    input logic                   nRST,
    input calc_pkg::calc_job_t    job,
    input logic                   job_valid,
    input logic                   job_ready,
    input calc_pkg::calc_result_t res,
    input logic                   res_valid,
    input logic                   res_ready,
    input calc_pkg::calc_result_t result,
    input logic                   result_valid,
    input logic                   result_ready
);
    job_hold: assert property (@(posedge clk) disable iff (nRST)
        job_valid && !job_ready |=> job_valid && $stable(job))
        else $error("Job dropped or changed before the controller took it");

    res_hold: assert property (@(posedge clk) disable iff (nRST)
        res_valid && !res_ready |=> res_valid && $stable(res))
        else $error("Controller result dropped or changed while stalled");

    // Display side must see a steady word while it stalls
    result_hold: assert property (@(posedge clk) disable iff (nRST)
        result_valid && !result_ready |=> result_valid && $stable(result))
        else $error("Output result dropped or changed while stalled");

    // One cycle out of reset the controller is ready and nothing is offered
    reset_quiet: assert property (@(posedge clk)
        $fell(nRST) |=> job_ready && !job_valid && !res_valid && !result_valid)
        else $error("Valid high or controller not ready after reset");

endmodule

bind calc_top calc_properties i_properties (.*);

//--- rtl/calc_top.sv
`timescale 1ns/10ps

module calc_top #(
    parameter int WIDTH = calc_pkg::DATA_WIDTH
) (
    input  logic                   clk,
    input  logic                   nRST,
    input  key_pkg::key_event_t    key,
    input  logic                   result_ready,
    output calc_pkg::calc_result_t result,
    output logic                   result_valid
);
    import calc_pkg::*;

    calc_job_t    job;          // Keypad side to controller
    logic         job_valid;
    logic         job_ready;
    calc_result_t res;          // Controller to output register
    logic         res_valid;
    logic         res_ready;

    key_entry #(
        .WIDTH(WIDTH)
    ) i_key_entry (
        .clk       (clk),
        .nRST      (nRST),
        .key       (key),
        .job_ready (job_ready),
        .job       (job),
        .job_valid (job_valid)
    );

    calc_control #(
        .WIDTH(WIDTH)
    ) i_calc_control (
        .clk       (clk),
        .nRST      (nRST),
        .job       (job),
        .job_valid (job_valid),
        .res_ready (res_ready),
        .job_ready (job_ready),
        .res       (res),
        .res_valid (res_valid)
    );

    result_stage i_result_stage (
        .clk          (clk),
        .nRST         (nRST),
        .res          (res),
        .res_valid    (res_valid),
        .result_ready (result_ready),
        .res_ready    (res_ready),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

//--- rtl/result_stage.sv
`timescale 1ns/10ps

module result_stage (
    input  logic                   clk,
    input  logic                   nRST,
    input  calc_pkg::calc_result_t res,
    input  logic                   res_valid,
    input  logic                   result_ready,
    output logic                   res_ready,
    output calc_pkg::calc_result_t result,
    output logic                   result_valid
);
    // Room when empty or the held word leaves now
    assign res_ready = !result_valid || result_ready;

    always_ff @(posedge clk or posedge nRST) begin
        if (nRST) begin
            result_valid <= 1'b0;
        end else if (res_ready) begin
            result_valid <= res_valid;      // Refill or drain
        end
    end

    always_ff @(posedge clk) begin
        if (res_ready && res_valid) begin
            result <= res;                  // Held until display takes it
        end
    end

endmodule

//--- rtl/calc_control.sv
`timescale 1ns/10ps

module calc_control #(
    parameter int WIDTH = calc_pkg::DATA_WIDTH
) (
    input  logic                   clk,
    input  logic                   nRST,
    input  calc_pkg::calc_job_t    job,
    input  logic                   job_valid,
    input  logic                   res_ready,
    output logic                   job_ready,
    output calc_pkg::calc_result_t res,
    output logic                   res_valid
);
    import calc_pkg::*;

    if (WIDTH != DATA_WIDTH) begin : g_width_check
        $error("calc_control WIDTH must equal calc_pkg::DATA_WIDTH");
    end

    typedef enum logic [1:0] {
        CTL_IDLE,       // Ready for a job
        CTL_WAIT_MUL,   // Multiplier running
        CTL_DONE        // Result offered downstream
    } ctl_state_t;

    ctl_state_t         state, state_next;
    logic               accept;         // Job transfer this cycle
    logic [WIDTH:0]     sum_ext;        // Extra bit holds carry or borrow
    logic [WIDTH-1:0]   mul_a, mul_b;   // Operands held for the multiplier
    logic               mul_start;
    logic               mul_finish;
    logic [2*WIDTH-1:0] product;

    shift_add_multiplier #(
        .WIDTH(WIDTH)
    ) i_multiplier (
        .clk          (clk),
        .nRST         (nRST),
        .start        (mul_start),
        .multiplicand (mul_a),
        .multiplier   (mul_b),
        .product      (product),
        .finish       (mul_finish)
    );

    always_comb begin
        accept     = job_valid && job_ready;
        state_next = state;
        case (state)
            CTL_IDLE:     if (accept) state_next = (job.op == OP_MUL) ? CTL_WAIT_MUL : CTL_DONE;
            CTL_WAIT_MUL: if (mul_finish) state_next = CTL_DONE;
            CTL_DONE:     if (res_ready) state_next = CTL_IDLE;
            default:      state_next = CTL_IDLE;
        endcase
        if (job.op == OP_SUB) begin
            sum_ext = {1'b0, job.operand_a} - {1'b0, job.operand_b};    // MSB set on borrow
        end else begin
            sum_ext = {1'b0, job.operand_a} + {1'b0, job.operand_b};    // MSB is carry
        end
    end

    assign res_valid = (state == CTL_DONE);

    always_ff @(posedge clk or posedge nRST) begin
        if (nRST) begin
            state     <= CTL_IDLE;
            job_ready <= 1'b0;              // Comes up one cycle after reset
            mul_start <= 1'b0;
        end else begin
            state     <= state_next;
            job_ready <= (state_next == CTL_IDLE);
            mul_start <= accept && (job.op == OP_MUL);  // Pulse with operands
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            mul_a <= job.operand_a;
            mul_b <= job.operand_b;
            if (job.op != OP_MUL) begin     // Add and sub settle right away
                res.value    <= sum_ext[WIDTH-1:0];
                res.overflow <= sum_ext[WIDTH];
            end
        end
        if ((state == CTL_WAIT_MUL) && mul_finish) begin
            res.value    <= product[WIDTH-1:0];
            res.overflow <= |product[2*WIDTH-1:WIDTH];  // High half nonzero
        end
    end

endmodule

//--- rtl/key_entry.sv
`timescale 1ns/10ps

module key_entry #(
    parameter int WIDTH = calc_pkg::DATA_WIDTH
) (
    input  logic                clk,
    input  logic                nRST,
    input  key_pkg::key_event_t key,
    input  logic                job_ready,
    output calc_pkg::calc_job_t job,
    output logic                job_valid
);
    import key_pkg::*;
    import calc_pkg::*;

    if (WIDTH != DATA_WIDTH) begin : g_width_check
        $error("key_entry WIDTH must equal calc_pkg::DATA_WIDTH");
    end

    typedef enum logic {
        ENTRY_FIRST,    // Building operand A
        ENTRY_SECOND    // Building operand B
    } entry_state_t;

    entry_state_t     state;
    logic             digit_key;    // Press of 0 to 9
    logic             op_key;       // Press of plus, minus or times
    logic [WIDTH-1:0] digit_ext;    // Digit widened to operand size

    // Operand times ten plus digit, wraps at 2^WIDTH
    function automatic logic [WIDTH-1:0] shift_in(input logic [WIDTH-1:0] value,
                                                  input logic [WIDTH-1:0] digit);
        return (value << 3) + (value << 1) + digit;
    endfunction

    function automatic calc_op_t key_to_op(input key_code_t code);
        case (code)
            KEY_SUB: return OP_SUB;
            KEY_MUL: return OP_MUL;
            default: return OP_ADD;
        endcase
    endfunction

    always_comb begin
        digit_key = key.press && (key.code <= KEY_9);
        op_key    = key.press && (key.code inside {KEY_ADD, KEY_SUB, KEY_MUL});
        digit_ext = WIDTH'(key.code);
    end

    always_ff @(posedge clk or posedge nRST) begin
        if (nRST) begin
            state     <= ENTRY_FIRST;
            job       <= '0;
            job_valid <= 1'b0;
        end else if (job_valid && job_ready) begin   // Handed off, start fresh
            state         <= ENTRY_FIRST;
            job_valid     <= 1'b0;
            job.operand_a <= '0;
            job.operand_b <= '0;
        end else if (key.press && (key.code == KEY_CLEAR)) begin
            state <= ENTRY_FIRST;
            if (!job_valid) begin                    // Pending job stays intact
                job.operand_a <= '0;
                job.operand_b <= '0;
            end
        end else if (!job_valid) begin               // Keys dropped while waiting
            case (state)
                ENTRY_FIRST: begin
                    if (digit_key) begin
                        job.operand_a <= shift_in(job.operand_a, digit_ext);
                    end else if (op_key) begin
                        job.op <= key_to_op(key.code);
                        state  <= ENTRY_SECOND;
                    end
                end
                ENTRY_SECOND: begin
                    if (digit_key) begin
                        job.operand_b <= shift_in(job.operand_b, digit_ext);
                    end else if (key.press && (key.code == KEY_EQUAL)) begin
                        job_valid <= 1'b1;           // Hold until accepted
                    end
                end
                default: state <= ENTRY_FIRST;
            endcase
        end
    end

endmodule

//--- rtl/shift_add_multiplier.sv
`timescale 1ns/10ps

module shift_add_multiplier #(
    parameter int WIDTH = calc_pkg::DATA_WIDTH
) (
    input  logic               clk,
    input  logic               nRST,
    input  logic               start,
    input  logic [WIDTH-1:0]   multiplicand,
    input  logic [WIDTH-1:0]   multiplier,
    output logic [2*WIDTH-1:0] product,
    output logic               finish
);
    localparam int CNT_W = $clog2(WIDTH + 1);

    logic [2*WIDTH-1:0] acc;        // Partial product
    logic [2*WIDTH-1:0] mcand_sh;   // Multiplicand, moves left each step
    logic [WIDTH-1:0]   mplier_sh;  // Multiplier, LSB tested each step
    logic [CNT_W-1:0]   count;      // Steps left
    logic               busy;

    assign product = acc;           // Final once finish pulses

    always_ff @(posedge clk or posedge nRST) begin
        if (nRST) begin
            busy   <= 1'b0;
            count  <= '0;
            finish <= 1'b0;
        end else if (start) begin
            busy   <= 1'b1;
            count  <= CNT_W'(WIDTH);
            finish <= 1'b0;
        end else if (busy) begin
            count <= count - 1'b1;
            if (count == CNT_W'(1)) begin   // Last bit this cycle
                busy   <= 1'b0;
                finish <= 1'b1;
            end
        end else begin
            finish <= 1'b0;                 // Single-cycle pulse
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            acc       <= '0;
            mcand_sh  <= {{WIDTH{1'b0}}, multiplicand};
            mplier_sh <= multiplier;
        end else if (busy) begin
            if (mplier_sh[0]) begin
                acc <= acc + mcand_sh;      // Add shifted multiplicand
            end
            mcand_sh  <= mcand_sh << 1;
            mplier_sh <= mplier_sh >> 1;
        end
    end

endmodule

//--- rtl/calc_pkg.sv
package calc_pkg;

    // Operand width the structs are built for
    parameter int DATA_WIDTH = 16;

    typedef enum logic [1:0] {
        OP_ADD = 2'd0,  // Carry out is overflow
        OP_SUB = 2'd1,  // Borrow is overflow
        OP_MUL = 2'd2   // Nonzero high half is overflow
    } calc_op_t;

    // One calculation as issued by the keypad side
    typedef struct packed {
        calc_op_t               op;
        logic [DATA_WIDTH-1:0]  operand_a;  // Left of the operator
        logic [DATA_WIDTH-1:0]  operand_b;  // Right of the operator
    } calc_job_t;

    // Result word toward the display
    typedef struct packed {
        logic [DATA_WIDTH-1:0]  value;      // Low WIDTH bits, wrapped
        logic                   overflow;   // Result did not fit
    } calc_result_t;

endpackage

//--- rtl/key_pkg.sv
package key_pkg;

    // Keypad codes, digits first so a range test finds them
    typedef enum logic [3:0] {
        KEY_0     = 4'd0,
        KEY_1     = 4'd1,
        KEY_2     = 4'd2,
        KEY_3     = 4'd3,
        KEY_4     = 4'd4,
        KEY_5     = 4'd5,
        KEY_6     = 4'd6,
        KEY_7     = 4'd7,
        KEY_8     = 4'd8,
        KEY_9     = 4'd9,
        KEY_ADD   = 4'd10,  // Plus
        KEY_SUB   = 4'd11,  // Minus
        KEY_MUL   = 4'd12,  // Times
        KEY_EQUAL = 4'd13,  // Issues the job
        KEY_CLEAR = 4'd14   // Back to first operand
    } key_code_t;

    typedef struct packed {
        logic      press;   // One-cycle strobe
        key_code_t code;    // Valid with press
    } key_event_t;

endpackage
